// ==== Makefile ====
SOURCES := sources.f $(wildcard logic/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: obj_dir/VdebugLinkTb

obj_dir/VdebugLinkTb: $(SOURCES)
	verilator --binary --assert --timescale 1ns/1ps --top-module debugLinkTb \
		-f sources.f -o VdebugLinkTb

run: obj_dir/VdebugLinkTb
	./obj_dir/VdebugLinkTb > sim.log
	cat sim.log
	! grep -q "TB FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== logic/asyncQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module asyncQueue #(
    parameter int Width = 8,
    parameter int DepthLog2 = linkPkg::DefaultQueueDepthLog2
) (
    input wire wclk,
    input wire wrstN,
    input wire rclk,
    input wire rrstN,
    queueIf.queue q
);
    localparam int Depth = 1 << DepthLog2;
    localparam int PtrWidth = DepthLog2 + 1;
    // Gray pointers of a full queue differ in exactly their top two bits
    localparam logic [PtrWidth-1:0] FullMask = PtrWidth'(3 << (DepthLog2 - 1));

    logic [Width-1:0] mem [Depth];

    logic [PtrWidth-1:0] wBin;
    logic [PtrWidth-1:0] wGray;
    logic [PtrWidth-1:0] wBinNext;
    logic [PtrWidth-1:0] rGraySync1;
    logic [PtrWidth-1:0] rGraySync2;
    logic full;
    logic doWrite;

    logic [PtrWidth-1:0] rBin;
    logic [PtrWidth-1:0] rGray;
    logic [PtrWidth-1:0] rBinNext;
    logic [PtrWidth-1:0] wGraySync1;
    logic [PtrWidth-1:0] wGraySync2;
    logic empty;
    logic doRead;

    // ========================================================================
    // Write side
    // ========================================================================
    assign full = (wGray ^ rGraySync2) == FullMask;
    assign q.writeOk = !full;
    assign doWrite = q.write && !full;
    assign wBinNext = wBin + PtrWidth'(doWrite);

    always_ff @(posedge wclk) begin
        if (!wrstN) begin
            wBin <= '0;
            wGray <= '0;
            rGraySync1 <= '0;
            rGraySync2 <= '0;
        end else begin
            wBin <= wBinNext;
            wGray <= (wBinNext >> 1) ^ wBinNext;
            rGraySync1 <= rGray;
            rGraySync2 <= rGraySync1;
        end
    end

    always_ff @(posedge wclk) begin
        if (doWrite) begin
            mem[wBin[DepthLog2-1:0]] <= q.writeData;
        end
    end

    // ========================================================================
    // Read side
    // ========================================================================
    assign empty = rGray == wGraySync2;
    assign q.readOk = !empty;
    assign q.readData = mem[rBin[DepthLog2-1:0]];
    assign doRead = q.read && !empty;
    assign rBinNext = rBin + PtrWidth'(doRead);

    always_ff @(posedge rclk) begin
        if (!rrstN) begin
            rBin <= '0;
            rGray <= '0;
            wGraySync1 <= '0;
            wGraySync2 <= '0;
        end else begin
            rBin <= rBinNext;
            rGray <= (rBinNext >> 1) ^ rBinNext;
            wGraySync1 <= wGray;
            wGraySync2 <= wGraySync1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/debugLink.sv ====
`timescale 1ns/1ps
`default_nettype none

module debugLink #(
    parameter int QueueDepthLog2 = linkPkg::DefaultQueueDepthLog2
) (
    input wire clk,
    input wire rstN,

    output logic [7:0] msgInType,
    output logic [7:0] msgInPayloadLen,
    output logic [msgPkg::MaxPayloadLen*8-1:0] msgInPayload,
    output logic msgInReady,
    input wire msgInTrigger,

    input wire [7:0] msgOutType,
    input wire [7:0] msgOutPayloadLen,
    input wire [7:0] msgOutPayload,
    output logic msgOutPayloadTrigger,

    input wire debugClk,
    input wire debugCs,
    input wire debugDi,
    output logic debugDo
);
    queueIf #(.Width(msgPkg::MsgLen * 8)) inQ ();
    queueIf #(.Width(8)) outQ ();

    msgPkg::msgWordT headWord;

    // ========================================================================
    // Host to chip
    // ========================================================================
    frameReceiver rx (
        .debugClk(debugClk), .debugCs(debugCs), .debugDi(debugDi), .inQ(inQ.writer)
    );

    asyncQueue #(.Width(msgPkg::MsgLen * 8), .DepthLog2(QueueDepthLog2)) inQueue (
        .wclk(debugClk), .wrstN(debugCs), .rclk(clk), .rrstN(rstN), .q(inQ.queue)
    );

    assign inQ.read = msgInTrigger;
    assign msgInReady = inQ.readOk;
    assign headWord = inQ.readData;
    assign msgInType = headWord.fields.msgType;
    assign msgInPayloadLen = headWord.fields.payloadLen;
    assign msgInPayload = headWord.fields.payload;

    // ========================================================================
    // Chip to host
    // ========================================================================
    frameSender tx (
        .clk(clk), .rstN(rstN),
        .msgOutType(msgOutType), .msgOutPayloadLen(msgOutPayloadLen),
        .msgOutPayload(msgOutPayload), .msgOutPayloadTrigger(msgOutPayloadTrigger),
        .outQ(outQ.writer)
    );

    asyncQueue #(.Width(8), .DepthLog2(QueueDepthLog2)) outQueue (
        .wclk(clk), .wrstN(rstN), .rclk(debugClk), .rrstN(debugCs), .q(outQ.queue)
    );

    serialTransmitter ser (
        .debugClk(debugClk), .debugCs(debugCs), .debugDo(debugDo), .outQ(outQ.reader)
    );

endmodule

`default_nettype wire

// ==== logic/frameReceiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameReceiver (
    input wire debugClk,
    input wire debugCs,
    input wire debugDi,
    queueIf.writer inQ
);
    localparam int IdxWidth = $clog2(msgPkg::MsgLen);

    localparam logic [1:0] WaitType = 2'd0;
    localparam logic [1:0] WaitLen = 2'd1;
    localparam logic [1:0] Payload = 2'd2;

    // Top bit is the sentinel, it reaches the top after a full byte
    logic [linkPkg::BitsPerByte:0] shiftReg;
    logic byteReady;
    logic [linkPkg::BitsPerByte-1:0] rxByte;

    logic [1:0] state;
    logic [7:0] payloadCount;
    msgPkg::msgWordT frame;

    logic takeType;
    logic takeLen;
    logic takePayload;
    logic storePayload;
    logic frameDone;
    logic [IdxWidth-1:0] payloadIdx;

    assign byteReady = shiftReg[linkPkg::BitsPerByte];
    assign rxByte = shiftReg[linkPkg::BitsPerByte-1:0];

    // Idle bytes between frames are skipped
    assign takeType = state == WaitType && byteReady && rxByte != linkPkg::IdleByte;
    assign takeLen = state == WaitLen && byteReady;
    assign frameDone = state == Payload && payloadCount >= frame.bytes[1];
    assign takePayload = state == Payload && !frameDone && byteReady;
    // Bytes past the stored payload are counted but not kept
    assign storePayload = takePayload && payloadCount < 8'(msgPkg::MaxPayloadLen);
    assign payloadIdx = IdxWidth'(msgPkg::HeaderLen) + payloadCount[IdxWidth-1:0];

    assign inQ.writeData = frame;

    // ========================================================================
    // Deserializer and frame FSM
    // ========================================================================
    always_ff @(posedge debugClk) begin
        if (!debugCs) begin
            // Sentinel alone, so the first edge with debugCs high takes bit 7
            shiftReg <= {{linkPkg::BitsPerByte{1'b0}}, 1'b1};
            state <= WaitType;
            payloadCount <= '0;
            inQ.write <= 1'b0;
        end else begin
            if (byteReady) begin
                shiftReg <= {{(linkPkg::BitsPerByte - 1){1'b0}}, 1'b1, debugDi};
            end else begin
                shiftReg <= {shiftReg[linkPkg::BitsPerByte-1:0], debugDi};
            end

            inQ.write <= frameDone;

            case (state)
                WaitType: begin
                    if (takeType) begin
                        state <= WaitLen;
                    end
                end
                WaitLen: begin
                    if (takeLen) begin
                        payloadCount <= '0;
                        state <= Payload;
                    end
                end
                Payload: begin
                    if (frameDone) begin
                        state <= WaitType;
                    end else if (takePayload) begin
                        payloadCount <= payloadCount + 8'd1;
                    end
                end
                default: state <= WaitType;
            endcase
        end
    end

    // Frame register, cleared by each new type byte
    always_ff @(posedge debugClk) begin
        if (takeType) begin
            frame.bytes <= '0;
            frame.bytes[0] <= rxByte;
        end else if (takeLen) begin
            frame.bytes[1] <= rxByte;
        end else if (storePayload) begin
            frame.bytes[payloadIdx] <= rxByte;
        end
    end

endmodule

`default_nettype wire

// ==== logic/frameSender.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameSender (
    input wire clk,
    input wire rstN,
    input wire [7:0] msgOutType,
    input wire [7:0] msgOutPayloadLen,
    input wire [7:0] msgOutPayload,
    output logic msgOutPayloadTrigger,
    queueIf.writer outQ
);
    localparam logic [2:0] Idle = 3'd0;
    localparam logic [2:0] SendType = 3'd1;
    // Length byte and every payload byte go out from here
    localparam logic [2:0] SendBody = 3'd2;
    localparam logic [2:0] PulseWait = 3'd3;
    localparam logic [2:0] Capture = 3'd4;
    localparam logic [2:0] Done = 3'd5;

    logic [2:0] state;
    logic [7:0] remaining;
    logic [7:0] outByte;
    logic sending;

    // A byte is held until the queue has room
    assign sending = state == SendType || state == SendBody;
    assign outQ.write = sending && outQ.writeOk;
    assign outQ.writeData = outByte;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= Idle;
            remaining <= '0;
            msgOutPayloadTrigger <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (msgOutType != linkPkg::IdleByte) begin
                        remaining <= msgOutPayloadLen;
                        state <= SendType;
                    end
                end
                SendType: begin
                    if (outQ.writeOk) begin
                        state <= SendBody;
                    end
                end
                SendBody: begin
                    if (outQ.writeOk) begin
                        msgOutPayloadTrigger <= 1'b1;
                        state <= (remaining == '0) ? Done : PulseWait;
                    end
                end
                // Client puts the next payload byte up during this cycle
                PulseWait: begin
                    msgOutPayloadTrigger <= 1'b0;
                    state <= Capture;
                end
                Capture: begin
                    remaining <= remaining - 8'd1;
                    state <= SendBody;
                end
                // Client drops or replaces msgOutType before Idle looks again
                Done: begin
                    msgOutPayloadTrigger <= 1'b0;
                    state <= Idle;
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            Idle: outByte <= msgOutType;
            SendType: begin
                if (outQ.writeOk) begin
                    outByte <= msgOutPayloadLen;
                end
            end
            Capture: outByte <= msgOutPayload;
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/linkPkg.sv ====
`default_nettype none

package linkPkg;

    // Serial bits per byte slot, sent MSB first
    localparam int BitsPerByte = 8;

    // A slot carrying this value holds no message data
    localparam logic [7:0] IdleByte = 8'h00;

    // Four entries per queue unless the top level overrides it
    localparam int DefaultQueueDepthLog2 = 2;

endpackage

`default_nettype wire

// ==== logic/msgPkg.sv ====
`default_nettype none

package msgPkg;

    // Type byte and length byte
    localparam int HeaderLen = 2;

    // Payload bytes kept per message, extra bytes on the wire are dropped
    localparam int MaxPayloadLen = 5;

    localparam int MsgLen = HeaderLen + MaxPayloadLen;

    // One stored message. Byte i of the word is byte i of the frame, so the
    // header lands in the low bytes and the struct lists its fields MSB first
    typedef union packed {
        logic [MsgLen-1:0][7:0] bytes;
        struct packed {
            logic [MaxPayloadLen-1:0][7:0] payload;
            logic [7:0] payloadLen;
            logic [7:0] msgType;
        } fields;
    } msgWordT;

endpackage

`default_nettype wire

// ==== logic/queueIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface queueIf #(
    parameter int Width = 8
);
    // Write side, write is a one-cycle strobe
    logic write;
    logic [Width-1:0] writeData;
    logic writeOk;

    // Read side, readData shows the head while readOk is high
    logic read;
    logic [Width-1:0] readData;
    logic readOk;

    modport writer (output write, output writeData, input writeOk);

    modport reader (output read, input readData, input readOk);

    modport queue (
        input write, input writeData, output writeOk,
        input read, output readData, output readOk
    );
endinterface

`default_nettype wire

// ==== logic/serialTransmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module serialTransmitter (
    input wire debugClk,
    input wire debugCs,
    output logic debugDo,
    queueIf.reader outQ
);
    // Sentinel sits below the data and reaches bit 7 when the last bit is out
    localparam logic [linkPkg::BitsPerByte-1:0] SentinelLast =
        {1'b1, {(linkPkg::BitsPerByte - 1){1'b0}}};

    logic [linkPkg::BitsPerByte:0] shiftReg;
    logic atBoundary;
    logic [linkPkg::BitsPerByte-1:0] nextByte;

    assign atBoundary = shiftReg[linkPkg::BitsPerByte-1:0] == SentinelLast;
    assign debugDo = shiftReg[linkPkg::BitsPerByte];

    // The queue only pops when it has a byte
    assign outQ.read = atBoundary;
    assign nextByte = outQ.readOk ? outQ.readData : linkPkg::IdleByte;

    always_ff @(posedge debugClk) begin
        if (!debugCs) begin
            // Line low, first edge with debugCs high is a slot boundary
            shiftReg <= {1'b0, SentinelLast};
        end else if (atBoundary) begin
            shiftReg <= {nextByte, 1'b1};
        end else begin
            shiftReg <= {shiftReg[linkPkg::BitsPerByte-1:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// ==== sim/debugLinkTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module debugLinkTb;
    localparam int Timeout = 3000;
    localparam int MaxPayload = msgPkg::MaxPayloadLen;

    logic clk = 1'b0;
    logic debugClk = 1'b0;
    logic rstN = 1'b0;
    logic [7:0] msgInType;
    logic [7:0] msgInPayloadLen;
    logic [MaxPayload*8-1:0] msgInPayload;
    logic msgInReady;
    logic msgInTrigger = 1'b0;
    logic [7:0] msgOutType = 8'h00;
    logic [7:0] msgOutPayloadLen = 8'h00;
    logic [7:0] msgOutPayload = 8'h00;
    logic msgOutPayloadTrigger;
    logic debugCs = 1'b0;
    logic debugDi = 1'b0;
    logic debugDo;

    // Bytes the host sends, bytes it has received, payload of the current test
    logic [7:0] hostTx[$];
    logic [7:0] hostRx[$];
    logic [7:0] pay[$];

    logic linkOn = 1'b0;
    logic [7:0] diShift = 8'h00;
    logic [2:0] diBit = 3'd0;
    logic doStarted = 1'b0;
    logic [7:0] rxShift = 8'h00;
    logic [2:0] rxBit = 3'd0;

    logic [31:0] rngState = 32'd16483;
    string testName = "";
    int errorCount = 0;
    int errorsAtStart = 0;
    int testsRun = 0;
    int testsFailed = 0;

    debugLink DUT (
        .clk(clk), .rstN(rstN),
        .msgInType(msgInType), .msgInPayloadLen(msgInPayloadLen),
        .msgInPayload(msgInPayload), .msgInReady(msgInReady), .msgInTrigger(msgInTrigger),
        .msgOutType(msgOutType), .msgOutPayloadLen(msgOutPayloadLen),
        .msgOutPayload(msgOutPayload), .msgOutPayloadTrigger(msgOutPayloadTrigger),
        .debugClk(debugClk), .debugCs(debugCs), .debugDi(debugDi), .debugDo(debugDo)
    );

    always #50 clk = ~clk;
    always #35 debugClk = ~debugClk;

    // ========================================================================
    // Host serial models
    // ========================================================================
    // One bit per debugClk, MSB first, idle bytes when nothing is queued
    always @(posedge debugClk) begin
        if (linkOn) begin
            if (diBit == 3'd0) begin
                diShift = (hostTx.size() > 0) ? hostTx.pop_front() : 8'h00;
            end
            debugCs <= 1'b1;
            debugDi <= diShift[7];
            diShift = diShift << 1;
            diBit = diBit + 3'd1;
        end
    end

    // First low phase with debugCs high comes before the first loaded bit
    always @(negedge debugClk) begin
        if (debugCs) begin
            if (doStarted) begin
                rxShift = {rxShift[6:0], debugDo};
                rxBit = rxBit + 3'd1;
                if (rxBit == 3'd0) begin
                    hostRx.push_back(rxShift);
                end
            end
            doStarted = 1'b1;
        end
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fillPayload(input int n);
        pay.delete();
        repeat (n) begin
            rngState = xorshift(rngState);
            pay.push_back(rngState[7:0]);
        end
    endtask

    task automatic checkValue(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: %s expected 0x%0h, actual 0x%0h",
                     testName, what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("%s: timed out waiting for %s", testName, what);
        errorCount++;
    endtask

    task automatic startTest(input string name);
        testName = name;
        errorsAtStart = errorCount;
    endtask

    task automatic endTest();
        testsRun++;
        if (errorCount == errorsAtStart) begin
            $display("%s: ok", testName);
        end else begin
            testsFailed++;
            $display("%s: failed", testName);
        end
    endtask

    task automatic queueFrame(input logic [7:0] msgType, input int len, input int offset);
        hostTx.push_back(msgType);
        hostTx.push_back(8'(len));
        for (int i = 0; i < len; i++) begin
            hostTx.push_back(pay[offset + i]);
        end
    endtask

    // Waits for the head message, checks it, consumes it and sees msgInReady fall
    task automatic expectMsgIn(input logic [7:0] msgType, input int len, input int offset);
        logic [MaxPayload*8-1:0] expPayload;
        int kept;
        int waited;
        expPayload = '0;
        kept = (len < MaxPayload) ? len : MaxPayload;
        for (int i = 0; i < kept; i++) begin
            expPayload = expPayload | ((MaxPayload * 8)'(pay[offset + i]) << (8 * i));
        end
        waited = 0;
        @(posedge clk);
        while (!msgInReady && waited < Timeout) begin
            @(posedge clk);
            waited++;
        end
        if (!msgInReady) begin
            reportTimeout("msgInReady");
        end else begin
            checkValue("msgInType", 64'(msgType), 64'(msgInType));
            checkValue("msgInPayloadLen", 64'(len), 64'(msgInPayloadLen));
            checkValue("msgInPayload", 64'(expPayload), 64'(msgInPayload));
            msgInTrigger <= 1'b1;
            @(posedge clk);
            msgInTrigger <= 1'b0;
            @(posedge clk);
            checkValue("msgInReady after read", 64'(0), 64'(msgInReady));
        end
    endtask

    task automatic waitRxBytes(input int n);
        int waited;
        waited = 0;
        while (hostRx.size() < n && waited < Timeout) begin
            @(posedge clk);
            waited++;
        end
        if (hostRx.size() < n) begin
            reportTimeout("bytes on debugDo");
        end
    endtask

    // Client side of the outbound trigger protocol
    task automatic runClient(input logic [7:0] msgType, input int len);
        int pulses;
        int extra;
        int waited;
        pulses = 0;
        extra = 0;
        waited = 0;
        @(posedge clk);
        msgOutType <= msgType;
        msgOutPayloadLen <= 8'(len);
        while (pulses < len + 1 && waited < Timeout) begin
            @(posedge clk);
            waited++;
            if (msgOutPayloadTrigger) begin
                pulses++;
                if (pulses <= len) begin
                    msgOutPayload <= pay[pulses - 1];
                end else begin
                    msgOutType <= 8'h00;
                end
            end
        end
        if (pulses < len + 1) begin
            reportTimeout("msgOutPayloadTrigger");
            msgOutType <= 8'h00;
        end
        // No pulse may follow the completion pulse
        repeat (30) begin
            @(posedge clk);
            if (msgOutPayloadTrigger) begin
                extra++;
            end
        end
        checkValue("trigger pulses", 64'(len + 1), 64'(pulses + extra));
    endtask

    task automatic expectSerialMsg(input logic [7:0] msgType, input int len);
        logic [7:0] first;
        int waited;
        first = 8'h00;
        waited = 0;
        while (first == 8'h00 && waited < Timeout) begin
            if (hostRx.size() > 0) begin
                first = hostRx.pop_front();
            end else begin
                @(posedge clk);
                waited++;
            end
        end
        if (first == 8'h00) begin
            reportTimeout("a type byte on debugDo");
        end else begin
            checkValue("type byte", 64'(msgType), 64'(first));
            waitRxBytes(len + 1);
            if (hostRx.size() > len) begin
                checkValue("length byte", 64'(len), 64'(hostRx.pop_front()));
                for (int i = 0; i < len; i++) begin
                    checkValue("payload byte", 64'(pay[i]), 64'(hostRx.pop_front()));
                end
            end
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        linkOn = 1'b1;
        @(posedge clk);

        startTest("reset state");
        checkValue("msgInReady", 64'(0), 64'(msgInReady));
        checkValue("msgOutPayloadTrigger", 64'(0), 64'(msgOutPayloadTrigger));
        waitRxBytes(4);
        while (hostRx.size() > 0) begin
            checkValue("idle byte on debugDo", 64'(0), 64'(hostRx.pop_front()));
        end
        endTest();

        startTest("single frame");
        fillPayload(3);
        queueFrame(8'h21, 3, 0);
        expectMsgIn(8'h21, 3, 0);
        endTest();

        startTest("two frames in order");
        fillPayload(4);
        queueFrame(8'h31, 2, 0);
        hostTx.push_back(8'h00);
        hostTx.push_back(8'h00);
        queueFrame(8'h32, 2, 2);
        expectMsgIn(8'h31, 2, 0);
        expectMsgIn(8'h32, 2, 2);
        endTest();

        startTest("long frame");
        fillPayload(10);
        queueFrame(8'h41, 7, 0);
        queueFrame(8'h42, 3, 7);
        expectMsgIn(8'h41, 7, 0);
        expectMsgIn(8'h42, 3, 7);
        endTest();

        startTest("client frame");
        fillPayload(4);
        runClient(8'h11, 4);
        expectSerialMsg(8'h11, 4);
        endTest();

        startTest("empty client frame");
        pay.delete();
        runClient(8'h12, 0);
        expectSerialMsg(8'h12, 0);
        endTest();

        $display("%0d tests, %0d failed, %0d failed checks", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/linkPkg.sv
logic/msgPkg.sv
logic/queueIf.sv
logic/asyncQueue.sv
logic/frameReceiver.sv
logic/serialTransmitter.sv
logic/frameSender.sv
logic/debugLink.sv
sim/debugLinkTb.sv
